// ==== rtl/lsu_pkg.sv ====
package lsu_pkg;

  // Data path and address width
  parameter int XLEN   = 32;
  // One enable bit per byte lane
  parameter int MASK_W = XLEN / 8;

  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } mem_op_t;

  // RV32I load funct3 encodings
  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct3_t;

  // RV32I store funct3 encodings
  typedef enum logic [2:0] {
    sb = 3'b000,
    sh = 3'b001,
    sw = 3'b010
  } store_funct3_t;

  // Incoming load or store request
  typedef struct packed {
    mem_op_t              op;
    logic [2:0]           funct3;
    logic [XLEN-1:0]      addr;
    logic [XLEN-1:0]      wdata;
  } lsu_req_t;

  // Load result, already extended
  typedef struct packed {
    logic [XLEN-1:0]      data;
  } lsu_res_t;

  // Data-cache request, address is word aligned
  typedef struct packed {
    logic                 read;
    logic                 write;
    logic [XLEN-1:0]      addr;
    logic [XLEN-1:0]      wdata;
    logic [MASK_W-1:0]    mbe;
  } dmem_req_t;

endpackage : lsu_pkg

// ==== rtl/credit_fifo.sv ====
`timescale 1ns/1ps

module credit_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output T     head,
  output logic not_empty,
  output logic full,
  output logic credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push   = push && !full;
  assign do_pop    = pop && not_empty;
  assign not_empty = (count != '0);
  assign full      = (count == CNT_W'(DEPTH));
  assign head      = mem[rd_ptr];

  // Storage, no reset needed on the entries
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap explicitly so DEPTH need not be a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count  <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      // One credit back per freed entry, a cycle after the pop
      credit <= do_pop;
    end
  end

endmodule : credit_fifo

// ==== rtl/mem_access.sv ====
`timescale 1ns/1ps

module mem_access (
  input  logic                     clk,
  input  logic                     rst_n,
  input  lsu_pkg::lsu_req_t        req_head,
  input  logic                     req_avail,
  output logic                     req_pop,
  input  logic                     res_space,
  output lsu_pkg::dmem_req_t       dmem,
  input  logic                     dmem_resp,
  input  logic [lsu_pkg::XLEN-1:0] dmem_rdata,
  output logic                     res_push,
  output lsu_pkg::lsu_res_t        res_data
);

  import lsu_pkg::*;

  typedef enum logic {
    st_idle,
    st_busy
  } state_t;

  state_t            state;
  lsu_req_t          req_q;
  logic              busy;
  logic              is_load;
  logic [1:0]        offset;
  logic [4:0]        bit_shift;
  logic [XLEN-1:0]   store_data;
  logic [MASK_W-1:0] store_mbe;
  logic [XLEN-1:0]   load_data;

  assign busy      = (state == st_busy);
  assign is_load   = (req_q.op == op_load);
  assign offset    = req_q.addr[1:0];
  assign bit_shift = {offset, 3'b000};

  // Loads need a free result slot before leaving the queue
  assign req_pop = !busy && req_avail && ((req_head.op == op_store) || res_space);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (req_pop) begin
            state <= st_busy;
          end
        end
        st_busy: begin
          // Access held until the cache answers
          if (dmem_resp) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_pop) begin
      req_q <= req_head;
    end
  end

  // Store data alignment and byte enables
  always_comb begin
    store_funct3_t store_f;
    store_f = store_funct3_t'(req_q.funct3);
    case (store_f)
      sb: begin
        store_data = req_q.wdata << bit_shift;
        store_mbe  = MASK_W'(4'b0001 << offset);
      end
      sh: begin
        store_data = req_q.wdata << bit_shift;
        // Upper lane drops off at offset 3
        store_mbe  = MASK_W'(4'b0011 << offset);
      end
      sw: begin
        store_data = req_q.wdata;
        store_mbe  = '1;
      end
      default: begin
        store_data = '0;
        store_mbe  = '0;
      end
    endcase
  end

  // Load extraction from the returned word
  always_comb begin
    load_funct3_t load_f;
    logic [7:0]   byte_sel;
    logic [15:0]  half_sel;
    logic         half_ok;
    load_f   = load_funct3_t'(req_q.funct3);
    byte_sel = dmem_rdata[bit_shift +: 8];
    half_sel = offset[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];
    // Halfwords only at offsets 0 and 2, others read as zero
    half_ok  = !offset[0];
    case (load_f)
      lb:      load_data = {{24{byte_sel[7]}}, byte_sel};
      lbu:     load_data = {24'b0, byte_sel};
      lh:      load_data = half_ok ? {{16{half_sel[15]}}, half_sel} : '0;
      lhu:     load_data = half_ok ? {16'b0, half_sel} : '0;
      lw:      load_data = dmem_rdata;
      default: load_data = dmem_rdata;
    endcase
  end

  assign dmem.read  = busy && is_load;
  assign dmem.write = busy && !is_load;
  assign dmem.addr  = {req_q.addr[XLEN-1:2], 2'b00};
  assign dmem.wdata = store_data;
  assign dmem.mbe   = store_mbe;

  // Result goes into the queue on the response edge
  assign res_push      = busy && is_load && dmem_resp;
  assign res_data.data = load_data;

endmodule : mem_access

// ==== rtl/result_port.sv ====
`timescale 1ns/1ps

module result_port #(
  parameter int RES_DEPTH   = 4,
  parameter int RES_CREDITS = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push,
  input  lsu_pkg::lsu_res_t push_data,
  output logic              space,
  input  logic              res_credit,
  output logic              res_valid,
  output lsu_pkg::lsu_res_t res
);

  import lsu_pkg::*;

  localparam int FREE_W = $clog2(RES_DEPTH + 1);
  localparam int CRED_W = $clog2(RES_CREDITS + 1);

  lsu_res_t          head;
  logic              not_empty;
  logic              slot_freed;
  logic              q_pop;
  logic [FREE_W-1:0] free_cnt;
  logic [CRED_W-1:0] cred_cnt;

  credit_fifo #(
    .T     (lsu_res_t),
    .DEPTH (RES_DEPTH)
  ) res_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (q_pop),
    .head      (head),
    .not_empty (not_empty),
    .full      (),
    .credit    (slot_freed)
  );

  // Send only with a downstream credit in hand
  assign q_pop = not_empty && (cred_cnt != '0);
  assign space = (free_cnt != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      free_cnt  <= FREE_W'(RES_DEPTH);
      cred_cnt  <= CRED_W'(RES_CREDITS);
      res_valid <= 1'b0;
    end else begin
      // Slot taken on push, returned one cycle after its pop
      free_cnt  <= free_cnt + FREE_W'(slot_freed) - FREE_W'(push);
      cred_cnt  <= cred_cnt + CRED_W'(res_credit) - CRED_W'(q_pop);
      res_valid <= q_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (q_pop) begin
      res <= head;
    end
  end

endmodule : result_port

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top #(
  parameter int REQ_DEPTH   = 4,
  parameter int RES_DEPTH   = 4,
  parameter int RES_CREDITS = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_valid,
  input  lsu_pkg::lsu_req_t        req,
  output logic                     req_credit,
  output lsu_pkg::dmem_req_t       dmem,
  input  logic                     dmem_resp,
  input  logic [lsu_pkg::XLEN-1:0] dmem_rdata,
  output logic                     res_valid,
  output lsu_pkg::lsu_res_t        res,
  input  logic                     res_credit
);

  import lsu_pkg::*;

  lsu_req_t req_head;
  logic     req_avail;
  logic     req_pop;
  logic     res_space;
  logic     res_push;
  lsu_res_t res_data;

  // Request queue, sender holds REQ_DEPTH credits
  credit_fifo #(
    .T     (lsu_req_t),
    .DEPTH (REQ_DEPTH)
  ) req_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (req_valid),
    .push_data (req),
    .pop       (req_pop),
    .head      (req_head),
    .not_empty (req_avail),
    .full      (),
    .credit    (req_credit)
  );

  mem_access mem_access_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_head   (req_head),
    .req_avail  (req_avail),
    .req_pop    (req_pop),
    .res_space  (res_space),
    .dmem       (dmem),
    .dmem_resp  (dmem_resp),
    .dmem_rdata (dmem_rdata),
    .res_push   (res_push),
    .res_data   (res_data)
  );

  result_port #(
    .RES_DEPTH   (RES_DEPTH),
    .RES_CREDITS (RES_CREDITS)
  ) result_port_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (res_push),
    .push_data  (res_data),
    .space      (res_space),
    .res_credit (res_credit),
    .res_valid  (res_valid),
    .res        (res)
  );

endmodule : lsu_top

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held over four rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule : tb_clock

// ==== verif/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb;

  import lsu_pkg::*;

  localparam int REQ_DEPTH   = 4;
  localparam int RES_DEPTH   = 4;
  localparam int RES_CREDITS = 2;
  localparam int STIM_COLS   = 7;
  localparam int STIM_WORDS  = 512;
  localparam int STIM_LINES  = STIM_WORDS / STIM_COLS;
  localparam int MEM_WORDS   = 64;
  // Consumer keeps its result credits in this cycle window
  localparam int HOLD_START  = 20;
  localparam int HOLD_END    = 220;

  logic            clk;
  logic            rst_n;
  logic            req_valid;
  lsu_req_t        req;
  logic            req_credit;
  dmem_req_t       dmem;
  logic            dmem_resp;
  logic [XLEN-1:0] dmem_rdata;
  logic            res_valid;
  lsu_res_t        res;
  logic            res_credit;

  logic [31:0] stim [STIM_WORDS];
  logic [31:0] mem_model [MEM_WORDS];
  logic [31:0] rng;
  int          n_lines;
  int          cycle;
  int          limit;
  int          sent;
  int          credits;
  int          credits_back;
  int          res_count;
  int          pending_ret;
  int          credits_returned;
  int          acc_q[$];
  int          exp_q[$];
  logic        mem_busy;
  logic [1:0]  wait_cnt;
  dmem_req_t   held;
  logic        done;

  tb_clock clock_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  lsu_top #(
    .REQ_DEPTH   (REQ_DEPTH),
    .RES_DEPTH   (RES_DEPTH),
    .RES_CREDITS (RES_CREDITS)
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .dmem       (dmem),
    .dmem_resp  (dmem_resp),
    .dmem_rdata (dmem_rdata),
    .res_valid  (res_valid),
    .res        (res),
    .res_credit (res_credit)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Column col of stimulus line
  function automatic logic [31:0] field(input int line, input int col);
    return stim[9'(line * STIM_COLS + col)];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("** Error: %s expected %08h actual %08h", name, expected, actual));
    end
  endtask

  task automatic sample_outputs();
    int idx;
    // Nothing may move before the first request
    if (sent == 0) begin
      check_value("idle dmem read", 32'd0, 32'(dmem.read));
      check_value("idle dmem write", 32'd0, 32'(dmem.write));
      check_value("idle req_credit", 32'd0, 32'(req_credit));
      check_value("idle res_valid", 32'd0, 32'(res_valid));
    end
    if (req_credit) begin
      credits_back++;
      credits++;
    end
    if (res_valid) begin
      if (exp_q.size() == 0) begin
        abort_run("A result came out with no load outstanding");
      end else begin
        idx = exp_q.pop_front();
        check_value($sformatf("request %0d load result", idx), field(idx, 6), res.data);
        res_count++;
        pending_ret++;
        check_value("results within credits", 32'd1,
                    32'(res_count <= RES_CREDITS + credits_returned));
      end
    end
  endtask

  task automatic start_access();
    int          idx;
    logic [31:0] op_word;
    logic [1:0]  exp_rw;
    if (acc_q.size() == 0) begin
      abort_run("The memory port started an access with no request outstanding");
    end else begin
      idx     = acc_q.pop_front();
      op_word = field(idx, 0);
      exp_rw  = op_word[0] ? 2'b01 : 2'b10;
      check_value($sformatf("request %0d read/write", idx), 32'(exp_rw),
                  32'({dmem.read, dmem.write}));
      check_value($sformatf("request %0d dmem addr", idx), field(idx, 2) & 32'hFFFF_FFFC,
                  dmem.addr);
      if (op_word[0]) begin
        check_value($sformatf("request %0d dmem mbe", idx), field(idx, 4), 32'(dmem.mbe));
        check_value($sformatf("request %0d dmem wdata", idx), field(idx, 5), dmem.wdata);
      end
      held     = dmem;
      mem_busy = 1'b1;
      rng      = lcg_next(rng);
      wait_cnt = rng[31:30];
    end
  endtask

  task automatic respond();
    logic [5:0]  w;
    logic [31:0] bits;
    w          = dmem.addr[7:2];
    dmem_rdata = mem_model[w];
    bits = {{8{dmem.mbe[3]}}, {8{dmem.mbe[2]}}, {8{dmem.mbe[1]}}, {8{dmem.mbe[0]}}};
    if (dmem.write) begin
      mem_model[w] = (mem_model[w] & ~bits) | (dmem.wdata & bits);
    end
    dmem_resp = 1'b1;
  endtask

  // Data cache model, one to four cycles per access
  task automatic run_memory();
    if (dmem_resp) begin
      dmem_resp = 1'b0;
      mem_busy  = 1'b0;
    end else if (dmem.read || dmem.write) begin
      if (!mem_busy) begin
        start_access();
      end else begin
        check_value("held dmem addr", held.addr, dmem.addr);
        check_value("held dmem wdata", held.wdata, dmem.wdata);
        check_value("held dmem controls", 32'({held.read, held.write, held.mbe}),
                    32'({dmem.read, dmem.write, dmem.mbe}));
      end
      if (wait_cnt == 2'd0) begin
        respond();
      end else begin
        wait_cnt = wait_cnt - 2'd1;
      end
    end else if (mem_busy) begin
      abort_run("The memory access was dropped before its response");
    end
  endtask

  task automatic return_credits();
    res_credit = 1'b0;
    if (pending_ret > 0 && (cycle < HOLD_START || cycle >= HOLD_END)) begin
      rng = lcg_next(rng);
      if (rng[31:30] != 2'd0) begin
        res_credit = 1'b1;
        pending_ret--;
        credits_returned++;
      end
    end
  endtask

  task automatic send_request();
    logic [31:0] op_word;
    logic [31:0] f3_word;
    req_valid = 1'b0;
    if (cycle > 3 && sent < n_lines && credits > 0) begin
      rng = lcg_next(rng);
      if (rng[31:29] != 3'd0) begin
        op_word    = field(sent, 0);
        f3_word    = field(sent, 1);
        req.op     = op_word[0] ? op_store : op_load;
        req.funct3 = f3_word[2:0];
        req.addr   = field(sent, 2);
        req.wdata  = field(sent, 3);
        req_valid  = 1'b1;
        credits--;
        acc_q.push_back(sent);
        if (!op_word[0]) begin
          exp_q.push_back(sent);
        end
        sent++;
      end
    end
  endtask

  initial begin
    req_valid        = 1'b0;
    req              = '0;
    dmem_resp        = 1'b0;
    dmem_rdata       = '0;
    res_credit       = 1'b0;
    rng              = 32'h6830_4852;
    n_lines          = 0;
    cycle            = 0;
    sent             = 0;
    credits          = REQ_DEPTH;
    credits_back     = 0;
    res_count        = 0;
    pending_ret      = 0;
    credits_returned = 0;
    mem_busy         = 1'b0;
    wait_cnt         = 2'd0;
    held             = '0;
    done             = 1'b0;
    for (int k = 0; k < STIM_WORDS; k++) begin
      stim[9'(k)] = '1;
    end
    $readmemh("verif/lsu_stim.txt", stim);
    while (n_lines < STIM_LINES && field(n_lines, 0) != 32'hFFFF_FFFF) begin
      n_lines++;
    end
    for (int k = 0; k < MEM_WORDS; k++) begin
      mem_model[6'(k)] = (32'(k) * 32'h0101_0101) ^ 32'hA5C3_0F96;
    end
    limit = n_lines * 40 + 200;
    wait (rst_n);
    while (!done) begin
      @(negedge clk);
      cycle++;
      if (cycle > limit) begin
        abort_run($sformatf("Timeout after %0d cycles, %0d of %0d requests sent",
                            cycle, sent, n_lines));
      end else begin
        sample_outputs();
        run_memory();
        return_credits();
        send_request();
        done = n_lines > 0 && sent == n_lines && acc_q.size() == 0 && !mem_busy &&
               !dmem_resp && exp_q.size() == 0;
      end
    end
    check_value("request credits returned", 32'(n_lines), 32'(credits_back));
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule : lsu_tb

// ==== verif/lsu_stim.txt ====
// op funct3 addr wdata exp_mbe exp_dmem_wdata exp_load_result
// Loads leave mbe and dmem wdata at 0, stores leave the result at 0
0 0 00000004 00000000 0 00000000 FFFFFF97 // lb
0 0 00000005 00000000 0 00000000 0000000E
0 0 00000006 00000000 0 00000000 FFFFFFC2
0 0 00000007 00000000 0 00000000 FFFFFFA4
0 4 00000004 00000000 0 00000000 00000097 // lbu
0 4 00000005 00000000 0 00000000 0000000E
0 4 00000006 00000000 0 00000000 000000C2
0 4 00000007 00000000 0 00000000 000000A4
0 1 00000004 00000000 0 00000000 00000E97 // lh
0 1 00000005 00000000 0 00000000 00000000
0 1 00000006 00000000 0 00000000 FFFFA4C2
0 1 00000007 00000000 0 00000000 00000000
0 5 00000004 00000000 0 00000000 00000E97 // lhu
0 5 00000005 00000000 0 00000000 00000000
0 5 00000006 00000000 0 00000000 0000A4C2
0 5 00000007 00000000 0 00000000 00000000
0 2 00000004 00000000 0 00000000 A4C20E97 // lw
0 2 00000005 00000000 0 00000000 A4C20E97
0 2 00000006 00000000 0 00000000 A4C20E97
0 2 00000007 00000000 0 00000000 A4C20E97
0 3 00000005 00000000 0 00000000 A4C20E97 // unknown load funct3
1 0 00000020 123456AB 1 123456AB 00000000 // sb
1 0 00000021 DEADBE11 2 ADBE1100 00000000
1 0 00000022 00000022 4 00220000 00000000
1 0 00000023 77665533 8 33000000 00000000
0 2 00000020 00000000 0 00000000 332211AB
0 4 00000021 00000000 0 00000000 00000011
1 1 00000024 FFFF5A5A 3 FFFF5A5A 00000000 // sh
1 1 00000031 0000BEEF 6 00BEEF00 00000000
1 1 00000032 12348001 C 80010000 00000000
1 1 00000033 0000C0DE 8 DE000000 00000000 // mask cut to 4 bits
0 2 00000024 00000000 0 00000000 ACCA5A5A
0 2 00000030 00000000 0 00000000 DE01EF9A
0 1 00000032 00000000 0 00000000 FFFFDE01
1 2 0000002A CAFEF00D F CAFEF00D 00000000 // sw
0 2 00000028 00000000 0 00000000 CAFEF00D
1 3 0000002D 11111111 0 00000000 00000000 // unknown store funct3
0 2 0000002C 00000000 0 00000000 AEC8049D

// ==== lsu_top.f ====
rtl/lsu_pkg.sv
rtl/credit_fifo.sv
rtl/mem_access.sv
rtl/result_port.sv
rtl/lsu_top.sv
verif/tb_clock.sv
verif/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --top-module lsu_tb -f lsu_top.f -o lsu_sim
./obj_dir/lsu_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
